// File: verilog/fifo_pkg.sv
// ----------------------------
// sync fifo shared definitions
// data word type, level flag and event pulse
// structs, default sizing for the top level
// ----------------------------
package fifo_pkg;

   // ----------------------------
   // payload
   // ----------------------------
   typedef logic [15:0] fifo_word_t;    // one stored data word

   // ----------------------------
   // level flags
   // ----------------------------
   // all four are registered in the controller from the next count
   typedef struct packed {
      logic full;                       // count equals depth
      logic afull;                      // count at or above afull threshold
      logic empty;                      // count is zero
      logic aempty;                     // count at or below aempty threshold
   } fifo_status_t;

   // ----------------------------
   // event pulses
   // ----------------------------
   // each one is high for a single cycle, the cycle after its cause
   typedef struct packed {
      logic wack;                       // write taken
      logic dvld;                       // read data on rd_data_o
      logic overflow;                   // write request while full
      logic underflow;                  // read request while empty
   } fifo_event_t;

   // ----------------------------
   // default sizing
   // ----------------------------
   localparam int FIFO_DEPTH_DEF = 16;  // entries
   localparam int AFULL_VAL_DEF  = 12;  // afull at this many entries
   localparam int AEMPTY_VAL_DEF = 4;   // aempty at this many or fewer

endpackage

// File: verilog/fifo_ctrl.sv
// ----------------------------
// sync fifo controller
// single occupancy counter, registered level flags,
// write/read address counters wrapping at DEPTH
// requests are gated by the registered full/empty flags
// ----------------------------
`timescale 1ns/1ps

module fifo_ctrl #(
   parameter  int DEPTH      = fifo_pkg::FIFO_DEPTH_DEF,
   parameter  int AFULL_VAL  = fifo_pkg::AFULL_VAL_DEF,
   parameter  int AEMPTY_VAL = fifo_pkg::AEMPTY_VAL_DEF,
   localparam int AW         = $clog2(DEPTH),        // address width
   localparam int CW         = $clog2(DEPTH) + 1     // count width, holds DEPTH
) (
   input  logic                   pos_clk,
   input  logic                   aresetn,
   input  logic                   wr_en_i,           // raw write request
   input  logic                   rd_en_i,           // raw read request
   output logic                   wr_acc_o,          // write accepted this cycle
   output logic                   rd_acc_o,          // read accepted this cycle
   output logic [AW-1:0]          wr_addr_o,
   output logic [AW-1:0]          rd_addr_o,
   output fifo_pkg::fifo_status_t status_o,
   output logic [CW-1:0]          count_o
);

   import fifo_pkg::*;

   // ----------------------------
   // constants
   // ----------------------------
   localparam logic [CW-1:0] FULL_CNT   = CW'(DEPTH);
   localparam logic [CW-1:0] AFULL_CNT  = CW'(AFULL_VAL);
   localparam logic [CW-1:0] AEMPTY_CNT = CW'(AEMPTY_VAL);
   localparam logic [AW-1:0] LAST_ADDR  = AW'(DEPTH - 1);

   // empty and almost empty out of reset, nothing else
   localparam fifo_status_t STATUS_RST = '{
      full:   1'b0,
      afull:  1'b0,
      empty:  1'b1,
      aempty: 1'b1
   };

   // ----------------------------
   // state
   // ----------------------------
   logic [CW-1:0] count_r;              // occupancy
   logic [CW-1:0] count_nxt;
   fifo_status_t  status_r;             // registered flags
   fifo_status_t  status_nxt;
   logic [AW-1:0] wr_addr_r;
   logic [AW-1:0] rd_addr_r;
   logic          wr_acc;
   logic          rd_acc;

   // address step with wrap after the last entry, DEPTH need not be a power of two
   function automatic logic [AW-1:0] addr_step(input logic [AW-1:0] addr);
      logic [AW-1:0] stepped;
      if (addr == LAST_ADDR) begin
         stepped = '0;
      end else begin
         stepped = addr + 1'b1;
      end
      return stepped;
   endfunction

   // ----------------------------
   // request gating
   // ----------------------------
   assign wr_acc = wr_en_i & ~status_r.full;    // blocked writes are dropped
   assign rd_acc = rd_en_i & ~status_r.empty;   // blocked reads are dropped

   // ----------------------------
   // next count and flags
   // ----------------------------
   always_comb begin
      unique case ({wr_acc, rd_acc})
         2'b10:   count_nxt = count_r + 1'b1;   // lone write
         2'b01:   count_nxt = count_r - 1'b1;   // lone read
         default: count_nxt = count_r;          // idle, or write and read together
      endcase
   end

   // flags look at the next count so they line up with count_o
   always_comb begin
      status_nxt.full   = (count_nxt == FULL_CNT);
      status_nxt.afull  = (count_nxt >= AFULL_CNT);
      status_nxt.empty  = (count_nxt == '0);
      status_nxt.aempty = (count_nxt <= AEMPTY_CNT);
   end

   // ----------------------------
   // registers
   // ----------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_r   <= '0;
         status_r  <= STATUS_RST;
         wr_addr_r <= '0;
         rd_addr_r <= '0;
      end else begin
         count_r  <= count_nxt;
         status_r <= status_nxt;
         if (wr_acc) begin
            wr_addr_r <= addr_step(wr_addr_r);  // next free slot
         end
         if (rd_acc) begin
            rd_addr_r <= addr_step(rd_addr_r);  // next word to read
         end
      end
   end

   // ----------------------------
   // outputs
   // ----------------------------
   assign wr_acc_o  = wr_acc;          // also the ram write enable
   assign rd_acc_o  = rd_acc;          // also the ram read enable
   assign wr_addr_o = wr_addr_r;
   assign rd_addr_o = rd_addr_r;
   assign status_o  = status_r;
   assign count_o   = count_r;

endmodule

// File: verilog/fifo_ram.sv
// ----------------------------
// fifo storage array
// DEPTH words of word_t, synchronous write,
// read word registered on an enabled read
// ----------------------------
`timescale 1ns/1ps

module fifo_ram #(
   parameter  int  DEPTH  = fifo_pkg::FIFO_DEPTH_DEF,
   parameter  type word_t = logic [15:0],
   localparam int  AW     = $clog2(DEPTH)
) (
   input  logic          pos_clk,
   input  logic          wr_en_i,      // accepted write from the controller
   input  logic [AW-1:0] wr_addr_i,
   input  word_t         wr_data_i,
   input  logic          rd_en_i,      // accepted read from the controller
   input  logic [AW-1:0] rd_addr_i,
   output word_t         rd_data_o     // valid the cycle after rd_en_i
);

   // ----------------------------
   // array
   // ----------------------------
   word_t mem [DEPTH];                 // stored words
   word_t rd_data_r;

   // write port
   always_ff @(posedge pos_clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read port
   // the controller blocks the read when empty and the write when full
   // so both ports never see the same address in one cycle
   always_ff @(posedge pos_clk) begin
      if (rd_en_i) begin
         rd_data_r <= mem[rd_addr_i];  // holds until the next read
      end
   end

   assign rd_data_o = rd_data_r;

endmodule

// File: verilog/fifo_events.sv
// ----------------------------
// fifo event pulses
// write ack, read data valid, overflow and underflow,
// each registered one cycle after its cause
// ----------------------------
`timescale 1ns/1ps

module fifo_events (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_acc_i,   // write accepted
   input  logic                  rd_acc_i,   // read accepted
   input  logic                  wr_en_i,    // raw write request
   input  logic                  rd_en_i,    // raw read request
   input  logic                  full_i,     // registered full
   input  logic                  empty_i,    // registered empty
   output fifo_pkg::fifo_event_t events_o
);

   import fifo_pkg::*;

   fifo_event_t events_nxt;
   fifo_event_t events_r;

   // ----------------------------
   // pulse sources
   // ----------------------------
   always_comb begin
      events_nxt.wack      = wr_acc_i;
      events_nxt.dvld      = rd_acc_i;              // lines up with the ram read register
      events_nxt.overflow  = wr_en_i & full_i;      // word is lost
      events_nxt.underflow = rd_en_i & empty_i;     // nothing to read
   end

   // ----------------------------
   // register
   // ----------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         events_r <= '0;
      end else begin
         events_r <= events_nxt;                    // single cycle, no hold
      end
   end

   assign events_o = events_r;

endmodule

// File: verilog/sync_fifo.sv
// ----------------------------
// single clock fifo, top level
// controller, storage array and event pulses
// standard read mode, data one cycle after the read
// ----------------------------
`timescale 1ns/1ps

module sync_fifo #(
   parameter  int DEPTH      = fifo_pkg::FIFO_DEPTH_DEF,
   parameter  int AFULL_VAL  = fifo_pkg::AFULL_VAL_DEF,
   parameter  int AEMPTY_VAL = fifo_pkg::AEMPTY_VAL_DEF,
   localparam int CW         = $clog2(DEPTH) + 1
) (
   input  logic                   pos_clk,
   input  logic                   aresetn,
   input  logic                   wr_en_i,
   input  fifo_pkg::fifo_word_t   wr_data_i,
   input  logic                   rd_en_i,
   output fifo_pkg::fifo_word_t   rd_data_o,
   output fifo_pkg::fifo_status_t status_o,
   output fifo_pkg::fifo_event_t  events_o,
   output logic [CW-1:0]          count_o
);

   import fifo_pkg::*;

   localparam int AW = $clog2(DEPTH);

   // ----------------------------
   // internal wires
   // ----------------------------
   logic          wr_acc;              // gated write, ram write enable
   logic          rd_acc;              // gated read, ram read enable
   logic [AW-1:0] wr_addr;
   logic [AW-1:0] rd_addr;

   // counter, flags, addresses
   fifo_ctrl #(
      .DEPTH      (DEPTH),
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) fifo_ctrl_i (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .wr_en_i   (wr_en_i),
      .rd_en_i   (rd_en_i),
      .wr_acc_o  (wr_acc),
      .rd_acc_o  (rd_acc),
      .wr_addr_o (wr_addr),
      .rd_addr_o (rd_addr),
      .status_o  (status_o),
      .count_o   (count_o)
   );

   // storage
   fifo_ram #(
      .DEPTH  (DEPTH),
      .word_t (fifo_word_t)
   ) fifo_ram_i (
      .pos_clk   (pos_clk),
      .wr_en_i   (wr_acc),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data_i),
      .rd_en_i   (rd_acc),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data_o)
   );

   // pulses, errors use the registered flags seen by the requester
   fifo_events fifo_events_i (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_acc_i (wr_acc),
      .rd_acc_i (rd_acc),
      .wr_en_i  (wr_en_i),
      .rd_en_i  (rd_en_i),
      .full_i   (status_o.full),
      .empty_i  (status_o.empty),
      .events_o (events_o)
   );

endmodule

// File: sim/sync_fifo_properties.sv
// ------------------------------
// sync fifo properties
// concurrent checks on flags, count and pulses,
// bound into the top level
// ------------------------------
`timescale 1ns/1ps

module sync_fifo_properties #(
   parameter  int DEPTH = fifo_pkg::FIFO_DEPTH_DEF,
   localparam int CW    = $clog2(DEPTH) + 1
) (
   input logic                   pos_clk,
   input logic                   aresetn,
   input logic                   wr_en_i,
   input logic                   rd_en_i,
   input fifo_pkg::fifo_status_t status_o,
   input fifo_pkg::fifo_event_t  events_o,
   input logic [CW-1:0]          count_o
);

   import fifo_pkg::*;

   int fail_cnt = 0;                   // failed assertions so far

   // flags exclusive
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(status_o.full && status_o.empty))
      else begin
         fail_cnt++;
         $error("full and empty high together");
      end

   // count bounded by depth
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      count_o <= CW'(DEPTH))
      else begin
         fail_cnt++;
         $error("count above depth");
      end

   // overflow only after a write into a full fifo
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      events_o.overflow |-> $past(wr_en_i && status_o.full))
      else begin
         fail_cnt++;
         $error("overflow without a write while full");
      end

   // dvld only after a read that was taken
   assert property (@(posedge pos_clk) disable iff (!aresetn)
      events_o.dvld |-> $past(rd_en_i && !status_o.empty))
      else begin
         fail_cnt++;
         $error("dvld without an accepted read");
      end

endmodule

bind sync_fifo sync_fifo_properties #(
   .DEPTH (DEPTH)
) props_i (
   .pos_clk  (pos_clk),
   .aresetn  (aresetn),
   .wr_en_i  (wr_en_i),
   .rd_en_i  (rd_en_i),
   .status_o (status_o),
   .events_o (events_o),
   .count_o  (count_o)
);

// File: sim/tb_sync_fifo.sv
// ------------------------------
// sync fifo testbench
// clock, reset, directed and random stimulus,
// queue reference model and per cycle checks
// ------------------------------
`timescale 1ns/1ps

module tb_sync_fifo;

   import fifo_pkg::*;

   localparam int DEPTH   = FIFO_DEPTH_DEF;
   localparam int CW      = $clog2(DEPTH) + 1;
   localparam int CLK_NS  = 20;
   localparam int RST_CYC = 8;

   // ------------------------------
   // test lengths and watchdog budget
   // ------------------------------
   localparam int T_RESET  = RST_CYC + 3;
   localparam int T_FILL   = 17 + 2;
   localparam int T_DRAIN  = 17 + 2;
   localparam int T_BOTH   = 8 + 12 + 2 + 8 + 2;
   localparam int T_RANDOM = 400 + 2;
   localparam int TOTAL_CYC  = T_RESET + T_FILL + T_DRAIN + T_BOTH + T_RANDOM;
   localparam int TIMEOUT_NS = 2 * TOTAL_CYC * CLK_NS;

   // dut signals
   logic         pos_clk;
   logic         aresetn;
   logic         wr_en;
   fifo_word_t   wr_data;
   logic         rd_en;
   fifo_word_t   rd_data;
   fifo_status_t status;
   fifo_event_t  events;
   logic [CW-1:0] count;

   // reference model
   fifo_word_t   model_q[$];           // words in write order
   int           exp_count  = 0;
   fifo_status_t exp_status = 4'b0011; // empty and aempty
   fifo_event_t  exp_events = '0;
   fifo_word_t   exp_rd     = '0;
   logic         wr_take;
   logic         rd_take;

   // bookkeeping
   int checks      = 0;
   int errors      = 0;
   int tests       = 0;
   int errors_mark = 0;                // errors at test start
   int wr_pct;
   int rd_pct;

   sync_fifo sync_fifo_i (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_data_o (rd_data),
      .status_o  (status),
      .events_o  (events),
      .count_o   (count)
   );

   always #(CLK_NS / 2) pos_clk = ~pos_clk;

   // ------------------------------
   // reference model of the requests seen at each edge
   // ------------------------------
   always @(posedge pos_clk) begin
      if (!aresetn) begin
         model_q.delete();
         exp_events = '0;
      end else begin
         wr_take = wr_en && (exp_count != DEPTH);  // blocked when full
         rd_take = rd_en && (exp_count != 0);      // blocked when empty
         exp_events.wack      = wr_take;
         exp_events.dvld      = rd_take;
         exp_events.overflow  = wr_en && (exp_count == DEPTH);
         exp_events.underflow = rd_en && (exp_count == 0);
         if (rd_take) begin
            exp_rd = model_q.pop_front();          // oldest word
         end
         if (wr_take) begin
            model_q.push_back(wr_data);
         end
      end
      exp_count         = model_q.size();
      exp_status.full   = (exp_count == DEPTH);
      exp_status.afull  = (exp_count >= AFULL_VAL_DEF);
      exp_status.empty  = (exp_count == 0);
      exp_status.aempty = (exp_count <= AEMPTY_VAL_DEF);
   end

   // compare one value against its expected value
   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      assert (exp == act) else begin
         errors++;
         $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   // outputs are settled at the falling edge
   always @(negedge pos_clk) begin
      check_val("count_o", 32'(exp_count), 32'(count));
      check_val("status_o", 32'(exp_status), 32'(status));
      check_val("events_o", 32'(exp_events), 32'(events));
      if (exp_events.dvld) begin
         check_val("rd_data_o", 32'(exp_rd), 32'(rd_data));  // only with dvld
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic drive(input logic wr, input logic rd, input fifo_word_t data);
      @(posedge pos_clk);
      wr_en   <= wr;
      rd_en   <= rd;
      wr_data <= data;
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, 1'b0, '0);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %s, %0d errors", tests, name,
               (errors == errors_mark) ? "ok" : "mismatch", errors - errors_mark);
      errors_mark = errors;
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   initial begin
      void'($urandom(32'h9ec8e8f5));   // single seed for the run
      pos_clk = 1'b0;
      aresetn = 1'b0;
      wr_en   = 1'b0;
      rd_en   = 1'b0;
      wr_data = '0;

      // reset values
      repeat (RST_CYC) @(posedge pos_clk);
      aresetn <= 1'b1;
      idle(2);
      @(negedge pos_clk);
      check_val("status_o", 32'h3, 32'(status));
      check_val("count_o", 32'h0, 32'(count));
      check_val("events_o", 32'h0, 32'(events));
      end_test("reset");

      // fill past full so the last write overflows
      for (int i = 0; i < 17; i++) begin
         drive(1'b1, 1'b0, 16'($urandom));
      end
      idle(2);
      @(negedge pos_clk);
      check_val("count_o", DEPTH, 32'(count));
      end_test("fill");

      // drain past empty with both addresses wrapping
      for (int i = 0; i < 17; i++) begin
         drive(1'b0, 1'b1, '0);
      end
      idle(2);
      end_test("drain");

      // write and read together at a middle level
      for (int i = 0; i < 8; i++) begin
         drive(1'b1, 1'b0, 16'($urandom));
      end
      for (int i = 0; i < 12; i++) begin
         drive(1'b1, 1'b1, 16'($urandom));
      end
      idle(2);
      @(negedge pos_clk);
      check_val("count_o", 32'd8, 32'(count));     // level held
      for (int i = 0; i < 8; i++) begin
         drive(1'b0, 1'b1, '0);
      end
      idle(2);
      end_test("write and read");

      // random mix with a shifting bias that reaches full and empty
      for (int i = 0; i < 400; i++) begin
         case (i / 100)
            0:       wr_pct = 80;
            1:       wr_pct = 20;
            2:       wr_pct = 60;
            default: wr_pct = 40;
         endcase
         rd_pct = 100 - wr_pct;
         drive(32'($urandom % 100) < 32'(wr_pct),
               32'($urandom % 100) < 32'(rd_pct),
               16'($urandom));
      end
      idle(2);
      end_test("random");

      $display("tests %0d, checks %0d, errors %0d, property failures %0d",
               tests, checks, errors, sync_fifo_i.props_i.fail_cnt);
      if (errors == 0 && sync_fifo_i.props_i.fail_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // ------------------------------
   // watchdog
   // ------------------------------
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tests did not complete within %0d ns", TIMEOUT_NS);
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: sim.f
verilog/fifo_pkg.sv
verilog/fifo_ctrl.sv
verilog/fifo_ram.sv
verilog/fifo_events.sv
verilog/sync_fifo.sv
sim/sync_fifo_properties.sv
sim/tb_sync_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the sync FIFO testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_sync_fifo

verilator --binary --timing --assert \
   --top-module "$TOP" \
   -f sim.f \
   -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/"V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
